// File: vlog.f
+incdir+hw
hw/memPkg.sv
hw/loadStoreQueue.sv
hw/dataPort.sv
hw/memCtrl.sv
hw/byteRam.sv
hw/memTop.sv
sim/memTopTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the memTop testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    --top-module memTopTb \
    -Mdir obj_dir \
    -o memTopSim \
    -f vlog.f

./obj_dir/memTopSim | tee sim.log

if grep -q "TEST OK" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/memTopTb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module memTopTb
    import memPkg::*;
();

    localparam int IdxW         = $clog2(`RAM_BYTES);
    localparam int WindowBase   = 'h200;
    localparam int PrefillWords = 17;       // 68 bytes cover a word load at the top of the window.
    localparam int NumRandom    = 200;
    localparam int NumPaused    = 50;
    localparam int TotalReqs    = 2 + 10 + 8 + PrefillWords + NumRandom + NumPaused;
    localparam int TimeoutCycles = 64 * (TotalReqs + 1);

    logic               clk;
    logic               rst;
    logic               rdy;
    logic [`WAIT_W-1:0] memWait;
    logic               reqEn;
    memReq_t            reqIn;
    logic               full;
    logic               respDone;
    memResp_t           resp;

    logic [7:0]         refMem [`RAM_BYTES];
    memResp_t           expQ [$];
    memResp_t           expResp;
    logic [`TAG_W-1:0]  tagCnt;
    int                 errCount;
    int                 respCount;
    int                 testNum;
    int                 testErrStart;
    int                 cycleCnt;

    memTop i_dut (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memWait  (memWait),
        .reqEn    (reqEn),
        .reqIn    (reqIn),
        .full     (full),
        .respDone (respDone),
        .resp     (resp)
    );

    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model

    // Requests run strictly in order, so updating the model when a request
    // is driven matches what the RAM sees.
    function automatic logic [31:0] refAccess(input memReq_t req);
        logic [31:0]     result;
        int              nBytes;
        int              i;
        logic [IdxW-1:0] idx;
        result = '0;
        nBytes = int'(req.len) + 1;
        for (i = 0; i < nBytes; i++) begin
            idx = req.addr[IdxW-1:0] + IdxW'(i);  // the RAM only decodes the low bits.
            if (req.isStore) begin
                refMem[idx] = req.data.word[8*i +: 8];
            end else begin
                result[8*i +: 8] = refMem[idx];  // the lowest address fills the low byte.
            end
        end
        return result;
    endfunction

    function automatic logic [`LEN_W-1:0] randomLen();
        case ($urandom_range(2, 0))
            0:       return 2'd0;
            1:       return 2'd1;
            default: return 2'd3;
        endcase
    endfunction

    task automatic checkValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errCount++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers

    task automatic stepCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sendReq(input logic st, input logic [`ADDR_W-1:0] addr,
                           input logic [31:0] data, input logic [`LEN_W-1:0] len);
        memReq_t  req;
        memResp_t exp;
        while (full) begin
            stepCycle();
        end
        req.isStore   = st;
        req.addr      = addr;
        req.data.word = data;
        req.len       = len;
        req.tag       = tagCnt;
        exp.tag       = tagCnt;
        exp.data.word = refAccess(req);
        expQ.push_back(exp);
        tagCnt = tagCnt + 4'd1;
        reqIn = req;
        reqEn = 1'b1;
        stepCycle();
        reqEn = 1'b0;
    endtask

    task automatic sendRandom();
        logic               st;
        logic [`ADDR_W-1:0] addr;
        logic [`LEN_W-1:0]  len;
        st      = 1'($urandom_range(1, 0));
        addr    = `ADDR_W'(WindowBase + $urandom_range(63, 0));
        len     = randomLen();
        memWait = `WAIT_W'($urandom_range(7, 0));
        sendReq(st, addr, $urandom, len);
    endtask

    task automatic pauseTraffic(input int n);
        rdy = 1'b0;
        repeat (n) stepCycle();
        rdy = 1'b1;
    endtask

    task automatic drainResponses();
        while (expQ.size() != 0) begin
            stepCycle();
        end
    endtask

    task automatic beginTest();
        testErrStart = errCount;
    endtask

    task automatic endTest(input string name);
        int newErr;
        drainResponses();
        newErr = errCount - testErrStart;
        testNum++;
        $display("test %0d %s: %s (%0d errors)", testNum, name,
                 (newErr == 0) ? "passed" : "failed", newErr);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response compare and timeout

    // A response counts at the edge where rdy lets the port move on.
    always @(negedge clk) begin
        if (!rst && respDone && rdy) begin
            if (expQ.size() == 0) begin
                $display("unexpected response with tag %0d while no request was outstanding",
                         resp.tag);
                errCount++;
            end else begin
                expResp = expQ.pop_front();
                checkValue("response tag", 32'(resp.tag), 32'(expResp.tag));
                checkValue("response data", resp.data.word, expResp.data.word);
                respCount++;
            end
        end
    end

    always @(posedge clk) begin
        cycleCnt++;
        if (cycleCnt >= TimeoutCycles) begin
            $display("timeout after %0d cycles: responses stopped arriving, %0d outstanding",
                     cycleCnt, expQ.size());
            $display("TEST FAILED");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // tests

    initial begin
        clk       = 1'b0;
        rst       = 1'b1;
        rdy       = 1'b1;
        memWait   = '0;
        reqEn     = 1'b0;
        reqIn     = '0;
        tagCnt    = '0;
        errCount  = 0;
        respCount = 0;
        testNum   = 0;
        cycleCnt  = 0;
        void'($urandom(95431));
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        beginTest();
        checkValue("full after reset", 32'(full), 32'd0);
        checkValue("respDone after reset", 32'(respDone), 32'd0);
        repeat (16) begin
            stepCycle();
            checkValue("respDone while idle", 32'(respDone), 32'd0);
        end
        endTest("after reset");

        beginTest();
        sendReq(1'b1, 17'h00040, 32'hA5C3_1E77, 2'd3);
        sendReq(1'b0, 17'h00040, 32'h0, 2'd3);
        endTest("word store and load");

        beginTest();
        memWait = 3'd2;
        sendReq(1'b1, 17'h00080, 32'h1122_3344, 2'd3);
        sendReq(1'b1, 17'h00081, 32'h0000_00AB, 2'd0);
        sendReq(1'b1, 17'h00082, 32'h0000_CDEF, 2'd1);
        sendReq(1'b0, 17'h00080, 32'h0, 2'd0);
        sendReq(1'b0, 17'h00081, 32'h0, 2'd0);
        sendReq(1'b0, 17'h00082, 32'h0, 2'd0);
        sendReq(1'b0, 17'h00083, 32'h0, 2'd0);
        sendReq(1'b0, 17'h00080, 32'h0, 2'd1);
        sendReq(1'b0, 17'h00082, 32'h0, 2'd1);
        sendReq(1'b0, 17'h00080, 32'h0, 2'd3);
        endTest("partial sizes");

        // a slow word load keeps the port busy while four more fill the queue.
        beginTest();
        memWait = 3'd7;
        sendReq(1'b0, 17'h00080, 32'h0, 2'd3);
        sendReq(1'b1, 17'h00100, 32'hDEAD_BEEF, 2'd3);
        sendReq(1'b0, 17'h00100, 32'h0, 2'd1);
        sendReq(1'b1, 17'h00102, 32'h0000_0055, 2'd0);
        sendReq(1'b0, 17'h00100, 32'h0, 2'd3);
        checkValue("full after burst", 32'(full), 32'd1);
        sendReq(1'b0, 17'h00103, 32'h0, 2'd0);
        sendReq(1'b1, 17'h00104, 32'h0102_0304, 2'd3);
        sendReq(1'b0, 17'h00101, 32'h0, 2'd3);
        endTest("burst with back-pressure");

        beginTest();
        memWait = 3'd0;
        for (int i = 0; i < PrefillWords; i++) begin
            sendReq(1'b1, `ADDR_W'(WindowBase + 4 * i), $urandom, 2'd3);
        end
        for (int i = 0; i < NumRandom; i++) begin
            sendRandom();
        end
        endTest("random mix");

        beginTest();
        for (int i = 0; i < NumPaused; i++) begin
            if ($urandom_range(2, 0) == 0) begin
                pauseTraffic(int'($urandom_range(8, 1)));
            end
            sendRandom();
        end
        pauseTraffic(5);
        endTest("pause");

        $display("done: %0d tests, %0d responses checked, %0d errors",
                 testNum, respCount, errCount);
        if (errCount == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: hw/memTop.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module memTop
    import memPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic [`WAIT_W-1:0] memWait,

    input  logic               reqEn,
    input  memReq_t            reqIn,
    output logic               full,

    output logic               respDone,
    output memResp_t           resp
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // queue to port to controller to RAM

    logic               portBusy;
    logic               issueEn;
    memReq_t            issueReq;
    logic               mcEn;
    memReq_t            mcReq;
    logic               mcDone;
    dataWord_u          mcData;
    logic               ramEn;
    logic               ramWe;
    logic [`ADDR_W-1:0] ramAddr;
    logic [7:0]         ramWdata;
    logic [7:0]         ramRdata;

    loadStoreQueue i_lsq (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .reqEn    (reqEn),
        .reqIn    (reqIn),
        .full     (full),
        .portBusy (portBusy),
        .issueEn  (issueEn),
        .issueReq (issueReq)
    );

    dataPort i_dataPort (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .issueEn  (issueEn),
        .issueReq (issueReq),
        .portBusy (portBusy),
        .mcEn     (mcEn),
        .mcReq    (mcReq),
        .mcDone   (mcDone),
        .mcData   (mcData),
        .respDone (respDone),
        .resp     (resp)
    );

    memCtrl i_memCtrl (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .memWait  (memWait),
        .mcEn     (mcEn),
        .mcReq    (mcReq),
        .mcDone   (mcDone),
        .mcData   (mcData),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

    byteRam i_byteRam (
        .clk      (clk),
        .ramEn    (ramEn),
        .ramWe    (ramWe),
        .ramAddr  (ramAddr),
        .ramWdata (ramWdata),
        .ramRdata (ramRdata)
    );

endmodule

// File: hw/byteRam.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module byteRam (
    input  logic               clk,
    input  logic               ramEn,
    input  logic               ramWe,
    input  logic [`ADDR_W-1:0] ramAddr,
    input  logic [7:0]         ramWdata,
    output logic [7:0]         ramRdata
);

    localparam int IdxW = $clog2(`RAM_BYTES);

    logic [7:0]      mem [`RAM_BYTES];
    logic [IdxW-1:0] idx;

    // Only the low address bits select a byte, so the RAM repeats
    // across the upper part of the address space.
    assign idx = ramAddr[IdxW-1:0];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one access per cycle

    always_ff @(posedge clk) begin
        if (ramEn) begin
            if (ramWe) begin
                mem[idx] <= ramWdata;
            end else begin
                ramRdata <= mem[idx];  // valid in the cycle after ramEn.
            end
        end
    end

endmodule

// File: hw/memCtrl.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module memCtrl
    import memPkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               rdy,
    input  logic [`WAIT_W-1:0] memWait,

    // data port side
    input  logic               mcEn,
    input  memReq_t            mcReq,
    output logic               mcDone,
    output dataWord_u          mcData,

    // RAM side
    output logic               ramEn,
    output logic               ramWe,
    output logic [`ADDR_W-1:0] ramAddr,
    output logic [7:0]         ramWdata,
    input  logic [7:0]         ramRdata
);

    localparam logic [1:0] StIdle    = 2'd0;
    localparam logic [1:0] StWait    = 2'd1;
    localparam logic [1:0] StAccess  = 2'd2;
    localparam logic [1:0] StCapture = 2'd3;

    localparam logic [`WAIT_W-1:0] LastWait = 1;

    logic [1:0]         state;
    logic [1:0]         byteState;
    logic [`WAIT_W-1:0] waitCnt;
    logic [`LEN_W-1:0]  byteIdx;
    logic [`LEN_W-1:0]  lastIdx;
    logic               isStore;
    logic [`ADDR_W-1:0] curAddr;
    dataWord_u          dataBuf;

    logic               start;
    logic               byteDone;
    logic               advance;
    logic               finish;

    // a byte either waits first or goes straight to its access cycle.
    assign byteState = (memWait == '0) ? StAccess : StWait;

    assign start    = (state == StIdle) && mcEn;
    assign byteDone = (state == StCapture) || (state == StAccess && isStore);
    assign advance  = byteDone && (byteIdx != lastIdx);
    assign finish   = byteDone && (byteIdx == lastIdx);

    assign ramEn    = rdy && (state == StAccess);
    assign ramWe    = isStore;
    assign ramAddr  = curAddr;
    assign ramWdata = dataBuf.bytes[byteIdx];
    assign mcData   = dataBuf;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // FSM

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= StIdle;
            mcDone  <= 1'b0;
            waitCnt <= '0;
            byteIdx <= '0;
        end else if (rdy) begin
            mcDone <= finish;
            if (start) begin
                byteIdx <= '0;
                waitCnt <= memWait;
                state   <= byteState;
            end else if (state == StWait) begin
                waitCnt <= waitCnt - 1'b1;
                if (waitCnt == LastWait) begin
                    state <= StAccess;
                end
            end else if (state == StAccess && !isStore) begin
                state <= StCapture;  // read data shows up on the next cycle.
            end else if (advance) begin
                byteIdx <= byteIdx + 1'b1;
                waitCnt <= memWait;
                state   <= byteState;
            end else if (finish) begin
                state <= StIdle;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and data word

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (start) begin
                isStore <= mcReq.isStore;
                curAddr <= mcReq.addr;
                lastIdx <= mcReq.len;
                // loads start from zero so the unused upper bytes stay clear.
                dataBuf <= mcReq.isStore ? mcReq.data : '0;
            end else begin
                if (advance) begin
                    curAddr <= curAddr + 1'b1;
                end
                if (state == StCapture) begin
                    dataBuf.bytes[byteIdx] <= ramRdata;
                end else if (finish) begin
                    dataBuf.word <= '0;  // a store reports zero.
                end
            end
        end
    end

endmodule

// File: hw/dataPort.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module dataPort
    import memPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      rdy,

    // queue side
    input  logic      issueEn,
    input  memReq_t   issueReq,
    output logic      portBusy,

    // controller side
    output logic      mcEn,
    output memReq_t   mcReq,
    input  logic      mcDone,
    input  dataWord_u mcData,

    // response to the core
    output logic      respDone,
    output memResp_t  resp
);

    logic [`TAG_W-1:0] heldTag;  // nickname of the request now in the controller.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // occupancy and pulses

    always_ff @(posedge clk) begin
        if (rst) begin
            portBusy <= 1'b0;
            mcEn     <= 1'b0;
            respDone <= 1'b0;
        end else if (rdy) begin
            mcEn     <= issueEn;    // the controller starts one cycle after issue.
            respDone <= mcDone;

            // issueEn needs an idle port, so it never meets mcDone.
            if (mcDone) begin
                portBusy <= 1'b0;
            end
            if (issueEn) begin
                portBusy <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and response registers

    always_ff @(posedge clk) begin
        if (rdy) begin
            if (issueEn) begin
                mcReq   <= issueReq;
                heldTag <= issueReq.tag;
            end
            if (mcDone) begin
                resp.data <= mcData;
                resp.tag  <= heldTag;
            end
        end
    end

endmodule

// File: hw/loadStoreQueue.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module loadStoreQueue
    import memPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    rdy,

    // core side
    input  logic    reqEn,
    input  memReq_t reqIn,
    output logic    full,

    // data port side
    input  logic    portBusy,
    output logic    issueEn,
    output memReq_t issueReq
);

    localparam int PtrW   = $clog2(`QUEUE_DEPTH);
    localparam int CountW = $clog2(`QUEUE_DEPTH + 1);

    memReq_t           entries [`QUEUE_DEPTH];
    logic [PtrW-1:0]   wrPtr;
    logic [PtrW-1:0]   rdPtr;
    logic [CountW-1:0] count;
    logic              empty;
    logic              push;

    function automatic logic [PtrW-1:0] nextPtr(input logic [PtrW-1:0] ptr);
        if (ptr == PtrW'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full  = (count == CountW'(`QUEUE_DEPTH));
    assign empty = (count == '0);
    assign push  = rdy && reqEn && !full;  // a request against a full queue is dropped.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // issue

    // The oldest entry goes out in the first cycle the data port is idle.
    // The port raises portBusy on the following edge, so one entry leaves at a time.
    assign issueEn  = rdy && !portBusy && !empty;
    assign issueReq = entries[rdPtr];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage and pointers

    always_ff @(posedge clk) begin
        if (push) begin
            entries[wrPtr] <= reqIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (issueEn) begin
                rdPtr <= nextPtr(rdPtr);
            end

            // a push and a pop in the same cycle leave the count alone.
            case ({push, issueEn})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: hw/memPkg.sv
`include "mem_macros.svh"

package memPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data word

    // The queue and the data port move whole words, while the controller
    // fills and drains the same word one byte at a time.
    typedef union packed {
        logic [`DATA_W-1:0]           word;
        logic [`DATA_W/8-1:0][7:0]    bytes;  // bytes[0] sits at the lowest address.
    } dataWord_u;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and response

    typedef struct packed {
        logic                 isStore;
        logic [`ADDR_W-1:0]   addr;
        dataWord_u            data;   // store data, ignored by loads.
        logic [`LEN_W-1:0]    len;
        logic [`TAG_W-1:0]    tag;
    } memReq_t;

    // loads carry zero-extended bytes, stores carry zero.
    typedef struct packed {
        dataWord_u            data;
        logic [`TAG_W-1:0]    tag;
    } memResp_t;

endpackage

// File: hw/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory path widths

`define ADDR_W      17      // byte address.
`define DATA_W      32
`define TAG_W       4       // request nickname handed out by the core.

// length code is the index of the last byte: 0 = 1 byte, 1 = 2 bytes, 3 = 4 bytes.
`define LEN_W       2

`define WAIT_W      3       // wait cycles ahead of every byte access.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sizes

`define QUEUE_DEPTH 4
`define RAM_BYTES   4096

`endif
